// ==== include/ruche_row_settings.svh ====
// Build settings for the ruche pod row.
// RUCHE_COL_W must hold every column index below RUCHE_NUM_PODS.
// RUCHE_HOP_W must hold the longest route, which is the local-only path.
// Pods are numbered from 0 at the west edge.

`ifndef RUCHE_ROW_SETTINGS_SVH
`define RUCHE_ROW_SETTINGS_SVH

// number of pod columns in the row
`define RUCHE_NUM_PODS 7

// columns skipped by one ruche hop
`define RUCHE_FACTOR 3

// entries in each pod input queue
`define RUCHE_QUEUE_DEPTH 2

// packet field widths
`define RUCHE_COL_W 3
`define RUCHE_HOP_W 4
`define RUCHE_PAYLOAD_W 16

`endif

// ==== rtl/ruche_pkg.sv ====
// Shared types for the ruche pod row.
// Field widths come from the settings header.

`default_nettype none

`include "ruche_row_settings.svh"

package ruche_pkg;

  // destination or source column of a packet
  typedef logic [`RUCHE_COL_W-1:0] col_t;

  // links traversed so far
  typedef logic [`RUCHE_HOP_W-1:0] hops_t;

  // user data, carried unchanged
  typedef logic [`RUCHE_PAYLOAD_W-1:0] payload_t;

  // four-phase handshake FSM
  typedef enum logic [1:0] {
    arb_idle,
    arb_wait_release
  } arb_state_e;

endpackage

`default_nettype wire

// ==== rtl/ruche_inject.sv ====
// West edge injector for the ruche pod row.
// Takes one packet per four-phase cycle; the destination must be below
// RUCHE_NUM_PODS. The hop count of a new packet is zero.
// Ack rises one cycle after pod 0 accepts the packet.

`timescale 1ns/1ps
`default_nettype none

`include "ruche_row_settings.svh"

module ruche_inject (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                in_req_i,
  input  ruche_pkg::col_t     in_dest_i,
  input  ruche_pkg::payload_t in_payload_i,
  output logic                in_ack_o,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output ruche_pkg::col_t     out_dest_o,
  output ruche_pkg::hops_t    out_hops_o,
  output ruche_pkg::payload_t out_payload_o
);
  import ruche_pkg::*;

  arb_state_e state_q;
  logic       valid_q;
  logic       capture;
  col_t       dest_q;
  payload_t   payload_q;

  // new request seen while nothing is pending
  assign capture = (state_q == arb_idle) && !valid_q && in_req_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= arb_idle;
      valid_q <= 1'b0;
    end else begin
      case (state_q)
        arb_idle: begin
          if (valid_q) begin
            // pod 0 took it, ack on the next cycle
            if (out_ready_i) begin
              valid_q <= 1'b0;
              state_q <= arb_wait_release;
            end
          end else if (in_req_i) begin
            valid_q <= 1'b1;
          end
        end
        arb_wait_release: begin
          if (!in_req_i) begin
            state_q <= arb_idle;
          end
        end
        default: state_q <= arb_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      dest_q    <= in_dest_i;
      payload_q <= in_payload_i;
    end
  end

  assign in_ack_o      = (state_q == arb_wait_release);
  assign out_valid_o   = valid_q;
  assign out_dest_o    = dest_q;
  assign out_hops_o    = '0;
  assign out_payload_o = payload_q;

  // only existing columns may be addressed
  a_dest_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    in_req_i |-> (int'(in_dest_i) < `RUCHE_NUM_PODS));

endmodule

`default_nettype wire

// ==== rtl/ruche_pod.sv ====
// One column node of the ruche row, eastbound traffic only.
// Local and ruche inputs each own a RUCHE_QUEUE_DEPTH entry queue.
// Destinations west of this column are not supported.
// A head stays granted until it leaves, so output valids hold.

`timescale 1ns/1ps
`default_nettype none

`include "ruche_row_settings.svh"

module ruche_pod #(
  parameter int pod_col_p = 0
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                lw_valid_i,
  output logic                lw_ready_o,
  input  ruche_pkg::col_t     lw_dest_i,
  input  ruche_pkg::hops_t    lw_hops_i,
  input  ruche_pkg::payload_t lw_payload_i,
  input  logic                rw_valid_i,
  output logic                rw_ready_o,
  input  ruche_pkg::col_t     rw_dest_i,
  input  ruche_pkg::hops_t    rw_hops_i,
  input  ruche_pkg::payload_t rw_payload_i,
  output logic                le_valid_o,
  input  logic                le_ready_i,
  output ruche_pkg::col_t     le_dest_o,
  output ruche_pkg::hops_t    le_hops_o,
  output ruche_pkg::payload_t le_payload_o,
  output logic                re_valid_o,
  input  logic                re_ready_i,
  output ruche_pkg::col_t     re_dest_o,
  output ruche_pkg::hops_t    re_hops_o,
  output ruche_pkg::payload_t re_payload_o,
  output logic                ej_valid_o,
  input  logic                ej_ready_i,
  output ruche_pkg::hops_t    ej_hops_o,
  output ruche_pkg::payload_t ej_payload_o
);
  import ruche_pkg::*;

  localparam int depth_lp = `RUCHE_QUEUE_DEPTH;
  localparam int ptr_w_lp = (depth_lp > 1) ? $clog2(depth_lp) : 1;
  localparam int cnt_w_lp = $clog2(depth_lp + 1);

  // queue 0 is local west and queue 1 is ruche west
  logic [1:0]          in_valid;
  logic [1:0]          in_ready;
  logic [1:0]          push;
  logic [1:0]          pop;
  logic [1:0]          nonempty;
  col_t                in_dest [2];
  hops_t               in_hops [2];
  payload_t            in_payload [2];
  col_t                q_dest [2][depth_lp];
  hops_t               q_hops [2][depth_lp];
  payload_t            q_payload [2][depth_lp];
  logic [ptr_w_lp-1:0] wr_ptr_q [2];
  logic [ptr_w_lp-1:0] rd_ptr_q [2];
  logic [cnt_w_lp-1:0] count_q [2];

  logic     rr_q;
  logic     lock_q;
  logic     grant_q;
  logic     sel;
  logic     head_valid;
  col_t     head_dest;
  hops_t    head_hops;
  hops_t    fwd_hops;
  payload_t head_payload;
  logic     to_ej;
  logic     to_re;
  logic     to_le;
  logic     out_ready;
  logic     fire;

  function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] p);
    if (int'(p) == depth_lp - 1) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign in_valid      = {rw_valid_i, lw_valid_i};
  assign in_dest[0]    = lw_dest_i;
  assign in_dest[1]    = rw_dest_i;
  assign in_hops[0]    = lw_hops_i;
  assign in_hops[1]    = rw_hops_i;
  assign in_payload[0] = lw_payload_i;
  assign in_payload[1] = rw_payload_i;
  assign lw_ready_o    = in_ready[0];
  assign rw_ready_o    = in_ready[1];

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      in_ready[i] = (int'(count_q[i]) < depth_lp);
      nonempty[i] = (count_q[i] != '0);
    end
  end

  assign push = in_valid & in_ready;
  assign pop  = {fire & sel, fire & !sel};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 2; i++) begin
        wr_ptr_q[i] <= '0;
        rd_ptr_q[i] <= '0;
        count_q[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (push[i]) begin
          wr_ptr_q[i] <= next_ptr(wr_ptr_q[i]);
        end
        if (pop[i]) begin
          rd_ptr_q[i] <= next_ptr(rd_ptr_q[i]);
        end
        if (push[i] && !pop[i]) begin
          count_q[i] <= count_q[i] + 1'b1;
        end else if (pop[i] && !push[i]) begin
          count_q[i] <= count_q[i] - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 2; i++) begin
      if (push[i]) begin
        q_dest[i][wr_ptr_q[i]]    <= in_dest[i];
        q_hops[i][wr_ptr_q[i]]    <= in_hops[i];
        q_payload[i][wr_ptr_q[i]] <= in_payload[i];
      end
    end
  end

  // round robin held while the winner waits on its output
  always_comb begin
    if (lock_q) begin
      sel = grant_q;
    end else if (nonempty[rr_q]) begin
      sel = rr_q;
    end else begin
      sel = !rr_q;
    end
  end

  assign head_valid   = nonempty[sel];
  assign head_dest    = q_dest[sel][rd_ptr_q[sel]];
  assign head_hops    = q_hops[sel][rd_ptr_q[sel]];
  assign head_payload = q_payload[sel][rd_ptr_q[sel]];

  // route choice
  assign to_ej     = (int'(head_dest) == pod_col_p);
  assign to_re     = !to_ej && (int'(head_dest) - pod_col_p >= `RUCHE_FACTOR);
  assign to_le     = !to_ej && !to_re;
  assign out_ready = (to_ej & ej_ready_i) | (to_re & re_ready_i) | (to_le & le_ready_i);
  assign fire      = head_valid & out_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q    <= 1'b0;
      lock_q  <= 1'b0;
      grant_q <= 1'b0;
    end else if (fire) begin
      lock_q <= 1'b0;
      rr_q   <= !sel;
    end else if (head_valid) begin
      lock_q  <= 1'b1;
      grant_q <= sel;
    end
  end

  assign fwd_hops = head_hops + 1'b1;

  assign le_valid_o   = head_valid & to_le;
  assign le_dest_o    = head_dest;
  assign le_hops_o    = fwd_hops;
  assign le_payload_o = head_payload;

  assign re_valid_o   = head_valid & to_re;
  assign re_dest_o    = head_dest;
  assign re_hops_o    = fwd_hops;
  assign re_payload_o = head_payload;

  // ejected packet keeps its count
  assign ej_valid_o   = head_valid & to_ej;
  assign ej_hops_o    = head_hops;
  assign ej_payload_o = head_payload;

  // a ruche hop must land inside the row
  a_ruche_in_row: assert property (@(posedge clk_i) disable iff (rst_i)
    re_valid_o |-> (pod_col_p + `RUCHE_FACTOR <= `RUCHE_NUM_PODS - 1));

  // a packet refused by a full queue stays offered unchanged
  for (genvar i = 0; i < 2; i++) begin : g_q_check
    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
      (in_valid[i] && !in_ready[i])
        |=> (in_valid[i] && $stable({in_dest[i], in_hops[i], in_payload[i]})));
  end

endmodule

`default_nettype wire

// ==== rtl/ruche_eject.sv ====
// Ejection collector for the ruche pod row.
// One packet is held at a time; pods wait while the output port is busy.
// out_col_o is the index of the pod that ejected the packet.
// Req rises again only after ack has been seen low.

`timescale 1ns/1ps
`default_nettype none

`include "ruche_row_settings.svh"

module ruche_eject (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic                [`RUCHE_NUM_PODS-1:0]    ej_valid_i,
  output logic                [`RUCHE_NUM_PODS-1:0]    ej_ready_o,
  input  ruche_pkg::hops_t    [`RUCHE_NUM_PODS-1:0]    ej_hops_i,
  input  ruche_pkg::payload_t [`RUCHE_NUM_PODS-1:0]    ej_payload_i,
  output logic                                         out_req_o,
  input  logic                                         out_ack_i,
  output ruche_pkg::col_t                              out_col_o,
  output ruche_pkg::hops_t                             out_hops_o,
  output ruche_pkg::payload_t                          out_payload_o
);
  import ruche_pkg::*;

  localparam int pods_lp = `RUCHE_NUM_PODS;

  arb_state_e state_q;
  logic       req_q;
  col_t       rr_q;
  col_t       pick;
  logic       pick_valid;
  logic       accept;
  col_t       col_q;
  hops_t      hops_q;
  payload_t   payload_q;

  // first valid pod at or after the pointer
  always_comb begin
    int idx;
    pick       = rr_q;
    pick_valid = 1'b0;
    for (int k = pods_lp - 1; k >= 0; k--) begin
      idx = (int'(rr_q) + k) % pods_lp;
      if (ej_valid_i[idx]) begin
        pick       = col_t'(idx);
        pick_valid = 1'b1;
      end
    end
  end

  assign accept = (state_q == arb_idle) && !req_q && pick_valid;

  always_comb begin
    ej_ready_o = '0;
    if (accept) begin
      ej_ready_o[pick] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= arb_idle;
      req_q   <= 1'b0;
      rr_q    <= '0;
    end else begin
      case (state_q)
        arb_idle: begin
          if (req_q) begin
            if (out_ack_i) begin
              req_q   <= 1'b0;
              state_q <= arb_wait_release;
            end
          end else if (pick_valid) begin
            req_q <= 1'b1;
            rr_q  <= (int'(pick) == pods_lp - 1) ? '0 : pick + 1'b1;
          end
        end
        arb_wait_release: begin
          if (!out_ack_i) begin
            state_q <= arb_idle;
          end
        end
        default: state_q <= arb_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      col_q     <= pick;
      hops_q    <= ej_hops_i[pick];
      payload_q <= ej_payload_i[pick];
    end
  end

  assign out_req_o     = req_q;
  assign out_col_o     = col_q;
  assign out_hops_o    = hops_q;
  assign out_payload_o = payload_q;

  // an ejection offer holds until the collector takes it
  for (genvar k = 0; k < pods_lp; k++) begin : g_ej_check
    a_ej_held: assert property (@(posedge clk_i) disable iff (rst_i)
      (ej_valid_i[k] && !ej_ready_o[k])
        |=> (ej_valid_i[k] && $stable({ej_hops_i[k], ej_payload_i[k]})));
  end

endmodule

`default_nettype wire

// ==== rtl/ruche_row.sv ====
// Top level of the ruche pod row, eastbound only.
// Ruche inputs of the first RUCHE_FACTOR pods are tied idle.
// The last pod's local east output and ruche outputs past the row edge
// are not consumed; no destination lies beyond them.

`timescale 1ns/1ps
`default_nettype none

`include "ruche_row_settings.svh"

module ruche_row (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                in_req_i,
  output logic                in_ack_o,
  input  ruche_pkg::col_t     in_dest_i,
  input  ruche_pkg::payload_t in_payload_i,
  output logic                out_req_o,
  input  logic                out_ack_i,
  output ruche_pkg::col_t     out_col_o,
  output ruche_pkg::hops_t    out_hops_o,
  output ruche_pkg::payload_t out_payload_o
);
  import ruche_pkg::*;

  localparam int pods_lp  = `RUCHE_NUM_PODS;
  localparam int ruche_lp = `RUCHE_FACTOR;

  // local links, entry x feeds pod x
  logic     [pods_lp:0]   lk_valid;
  logic     [pods_lp:0]   lk_ready;
  col_t     [pods_lp:0]   lk_dest;
  hops_t    [pods_lp:0]   lk_hops;
  payload_t [pods_lp:0]   lk_payload;

  // ruche inputs by receiving pod
  logic     [pods_lp-1:0] rw_valid;
  logic     [pods_lp-1:0] rw_ready;
  col_t     [pods_lp-1:0] rw_dest;
  hops_t    [pods_lp-1:0] rw_hops;
  payload_t [pods_lp-1:0] rw_payload;

  // ruche outputs by sending pod
  logic     [pods_lp-1:0] re_valid;
  logic     [pods_lp-1:0] re_ready;
  col_t     [pods_lp-1:0] re_dest;
  hops_t    [pods_lp-1:0] re_hops;
  payload_t [pods_lp-1:0] re_payload;

  logic     [pods_lp-1:0] ej_valid;
  logic     [pods_lp-1:0] ej_ready;
  hops_t    [pods_lp-1:0] ej_hops;
  payload_t [pods_lp-1:0] ej_payload;

  ruche_inject inject_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .in_req_i     (in_req_i),
    .in_dest_i    (in_dest_i),
    .in_payload_i (in_payload_i),
    .in_ack_o     (in_ack_o),
    .out_valid_o  (lk_valid[0]),
    .out_ready_i  (lk_ready[0]),
    .out_dest_o   (lk_dest[0]),
    .out_hops_o   (lk_hops[0]),
    .out_payload_o(lk_payload[0])
  );

  for (genvar x = 0; x < pods_lp; x++) begin : g_pod
    ruche_pod #(
      .pod_col_p(x)
    ) pod_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .lw_valid_i  (lk_valid[x]),
      .lw_ready_o  (lk_ready[x]),
      .lw_dest_i   (lk_dest[x]),
      .lw_hops_i   (lk_hops[x]),
      .lw_payload_i(lk_payload[x]),
      .rw_valid_i  (rw_valid[x]),
      .rw_ready_o  (rw_ready[x]),
      .rw_dest_i   (rw_dest[x]),
      .rw_hops_i   (rw_hops[x]),
      .rw_payload_i(rw_payload[x]),
      .le_valid_o  (lk_valid[x+1]),
      .le_ready_i  (lk_ready[x+1]),
      .le_dest_o   (lk_dest[x+1]),
      .le_hops_o   (lk_hops[x+1]),
      .le_payload_o(lk_payload[x+1]),
      .re_valid_o  (re_valid[x]),
      .re_ready_i  (re_ready[x]),
      .re_dest_o   (re_dest[x]),
      .re_hops_o   (re_hops[x]),
      .re_payload_o(re_payload[x]),
      .ej_valid_o  (ej_valid[x]),
      .ej_ready_i  (ej_ready[x]),
      .ej_hops_o   (ej_hops[x]),
      .ej_payload_o(ej_payload[x])
    );

    if (x < ruche_lp) begin : g_rw_tie
      // west edge, nothing arrives by ruche
      assign rw_valid[x]   = 1'b0;
      assign rw_dest[x]    = '0;
      assign rw_hops[x]    = '0;
      assign rw_payload[x] = '0;
    end else begin : g_rw_link
      assign rw_valid[x]   = re_valid[x-ruche_lp];
      assign rw_dest[x]    = re_dest[x-ruche_lp];
      assign rw_hops[x]    = re_hops[x-ruche_lp];
      assign rw_payload[x] = re_payload[x-ruche_lp];
    end

    if (x + ruche_lp < pods_lp) begin : g_re_link
      assign re_ready[x] = rw_ready[x+ruche_lp];
    end else begin : g_re_edge
      assign re_ready[x] = 1'b0;
    end
  end

  // east edge of the local chain
  assign lk_ready[pods_lp] = 1'b0;

  ruche_eject eject_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ej_valid_i   (ej_valid),
    .ej_ready_o   (ej_ready),
    .ej_hops_i    (ej_hops),
    .ej_payload_i (ej_payload),
    .out_req_o    (out_req_o),
    .out_ack_i    (out_ack_i),
    .out_col_o    (out_col_o),
    .out_hops_o   (out_hops_o),
    .out_payload_o(out_payload_o)
  );

endmodule

`default_nettype wire

// ==== test/ruche_row_tb.sv ====
// Directed testbench for the ruche pod row.
// Expected hops assume all traffic enters at column 0 and moves east.
// Protocol checks on both four-phase ports run at the falling edge.
// The first error stops the run.

`timescale 1ns/1ps
`default_nettype none

`include "ruche_row_settings.svh"

module ruche_row_tb;
  import ruche_pkg::*;

  // about 60 packets of under 150 cycles each plus the 60 cycle stall
  localparam int timeout_cycles_lp = 20000;
  localparam int stream_len_lp     = 40;
  localparam int stall_len_lp      = 12;
  localparam int stall_cycles_lp   = 60;
  localparam int drain_cycles_lp   = 30;

  logic     clk;
  logic     rst;
  logic     in_req;
  logic     in_ack;
  col_t     in_dest;
  payload_t in_payload;
  logic     out_req;
  logic     out_ack;
  col_t     out_col;
  hops_t    out_hops;
  payload_t out_payload;

  int seed;
  int cycle_count;
  int exp_col [int];
  int exp_hops [int];
  int seen [int];

  // previous falling edge samples for the protocol monitor
  logic     p_in_req;
  logic     p_in_ack;
  logic     p_out_req;
  logic     p_out_ack;
  col_t     p_col;
  hops_t    p_hops;
  payload_t p_payload;

  ruche_row ruche_row_i (
    .clk_i        (clk),
    .rst_i        (rst),
    .in_req_i     (in_req),
    .in_ack_o     (in_ack),
    .in_dest_i    (in_dest),
    .in_payload_i (in_payload),
    .out_req_o    (out_req),
    .out_ack_i    (out_ack),
    .out_col_o    (out_col),
    .out_hops_o   (out_hops),
    .out_payload_o(out_payload)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int actual, input int expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles_lp) begin
      $display("The run timed out after %0d cycles without finishing.", cycle_count);
      stop_on_failure();
    end
  end

  // four-phase ordering and output data stability
  always @(negedge clk) begin
    if (!rst) begin
      if (!p_in_ack && in_ack) check_value("in_req_i at in_ack_o rise", int'(p_in_req), 1);
      if (p_in_ack && !in_ack) check_value("in_req_i at in_ack_o fall", int'(p_in_req), 0);
      if (!p_out_req && out_req) check_value("out_ack_i at out_req_o rise", int'(p_out_ack), 0);
      if (p_out_req && !out_req) check_value("out_ack_i at out_req_o fall", int'(p_out_ack), 1);
      if (p_out_req && out_req) begin
        check_value("out_col_o", int'(out_col), int'(p_col));
        check_value("out_hops_o", int'(out_hops), int'(p_hops));
        check_value("out_payload_o", int'(out_payload), int'(p_payload));
      end
    end
    p_in_req  <= in_req;
    p_in_ack  <= in_ack;
    p_out_req <= out_req;
    p_out_ack <= out_ack;
    p_col     <= out_col;
    p_hops    <= out_hops;
    p_payload <= out_payload;
  end

  // one ruche hop per RUCHE_FACTOR columns and local hops for the rest
  function automatic int expected_hops(input int dest);
    return dest / `RUCHE_FACTOR + dest % `RUCHE_FACTOR;
  endfunction

  task automatic wait_in_ack(input logic level);
    do @(negedge clk); while (in_ack !== level);
  endtask

  task automatic wait_out_req(input logic level);
    do @(negedge clk); while (out_req !== level);
  endtask

  task automatic send_packet(input col_t dest, input payload_t payload, input int hold);
    @(posedge clk);
    in_dest    <= dest;
    in_payload <= payload;
    in_req     <= 1'b1;
    wait_in_ack(1'b1);
    // ack must stay up while req is held
    repeat (hold) begin
      @(negedge clk);
      check_value("in_ack_o", int'(in_ack), 1);
    end
    @(posedge clk);
    in_req <= 1'b0;
    wait_in_ack(1'b0);
  endtask

  task automatic receive_packet(input int delay, input int hold, output col_t col,
                                output hops_t hops, output payload_t payload);
    wait_out_req(1'b1);
    col     = out_col;
    hops    = out_hops;
    payload = out_payload;
    repeat (delay) @(posedge clk);
    @(posedge clk);
    out_ack <= 1'b1;
    wait_out_req(1'b0);
    // no new request while ack is still high
    repeat (hold) begin
      @(negedge clk);
      check_value("out_req_o", int'(out_req), 0);
    end
    @(posedge clk);
    out_ack <= 1'b0;
  endtask

  task automatic clear_scoreboard();
    exp_col.delete();
    exp_hops.delete();
    seen.delete();
  endtask

  task automatic register_packet(input int key, input int dest);
    exp_col[key]  = dest;
    exp_hops[key] = expected_hops(dest);
    seen[key]     = 0;
  endtask

  task automatic collect_packet(input int delay, input int hold);
    col_t     col;
    hops_t    hops;
    payload_t payload;
    int       key;
    receive_packet(delay, hold, col, hops, payload);
    key = int'(payload);
    if (!exp_col.exists(key)) begin
      $display("A packet with payload %0d arrived that was never sent.", key);
      stop_on_failure();
    end
    seen[key] = seen[key] + 1;
    if (seen[key] > 1) begin
      $display("The packet with payload %0d arrived more than once.", key);
      stop_on_failure();
    end
    check_value("out_col_o", int'(col), exp_col[key]);
    check_value("out_hops_o", int'(hops), exp_hops[key]);
  endtask

  // a stray or repeated packet would raise a new request
  task automatic check_port_idle();
    repeat (drain_cycles_lp) begin
      @(negedge clk);
      check_value("out_req_o", int'(out_req), 0);
    end
  endtask

  task automatic reset_state_check();
    @(negedge clk);
    check_value("in_ack_o", int'(in_ack), 0);
    check_value("out_req_o", int'(out_req), 0);
  endtask

  task automatic single_packets();
    col_t     col;
    hops_t    hops;
    payload_t payload;
    payload_t sent;
    for (int d = 0; d < `RUCHE_NUM_PODS; d++) begin
      sent = payload_t'($random(seed));
      send_packet(col_t'(d), sent, 0);
      receive_packet(0, 0, col, hops, payload);
      check_value("out_col_o", int'(col), d);
      check_value("out_payload_o", int'(payload), int'(sent));
      check_value("out_hops_o", int'(hops), expected_hops(d));
    end
  endtask

  task automatic random_stream();
    int dest;
    clear_scoreboard();
    fork
      begin
        for (int i = 0; i < stream_len_lp; i++) begin
          dest = $unsigned($random(seed)) % `RUCHE_NUM_PODS;
          register_packet(i, dest);
          send_packet(col_t'(dest), payload_t'(i), 0);
        end
      end
      begin
        for (int i = 0; i < stream_len_lp; i++) begin
          collect_packet($unsigned($random(seed)) % 5, 0);
        end
      end
    join
    check_port_idle();
  endtask

  task automatic back_pressure();
    int dest;
    clear_scoreboard();
    fork
      begin
        for (int i = 0; i < stall_len_lp; i++) begin
          dest = $unsigned($random(seed)) % `RUCHE_NUM_PODS;
          register_packet(100 + i, dest);
          send_packet(col_t'(dest), payload_t'(100 + i), 0);
        end
      end
      begin
        // row fills up behind the stalled output
        collect_packet(stall_cycles_lp, 0);
        for (int i = 1; i < stall_len_lp; i++) begin
          collect_packet(0, 0);
        end
      end
    join
    check_port_idle();
  endtask

  task automatic handshake_release();
    clear_scoreboard();
    register_packet(500, 1);
    register_packet(501, 0);
    send_packet(col_t'(1), payload_t'(500), 5);
    send_packet(col_t'(0), payload_t'(501), 0);
    // second packet waits while ack is held after the first
    collect_packet(2, 6);
    collect_packet(0, 0);
    check_port_idle();
  endtask

  initial begin
    seed        = 77;
    cycle_count = 0;
    rst         = 1'b1;
    in_req      = 1'b0;
    in_dest     = '0;
    in_payload  = '0;
    out_ack     = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    reset_state_check();
    single_packets();
    random_stream();
    back_pressure();
    handshake_release();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
rtl/ruche_pkg.sv
rtl/ruche_inject.sv
rtl/ruche_pod.sv
rtl/ruche_eject.sv
rtl/ruche_row.sv
test/ruche_row_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ruche_row_tb \
  -f filelist.f \
  -o ruche_row_sim

# the simulator status is masked by tee, the log decides
./obj_dir/ruche_row_sim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q "TEST OK" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
